// File: icacheSys.f
+incdir+hdl
hdl/apbPkg.sv
hdl/icacheTypesPkg.sv
hdl/tagStore.sv
hdl/dataStore.sv
hdl/missController.sv
hdl/icacheTop.sv
test/icacheTb.sv

// File: Makefile
# Verilator build and run of the instruction cache testbench

TOP       ?= icacheTb
FILELIST  ?= icacheSys.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_MSG  ?= RESULT: PASS

SRCS := $(shell grep -v '^+' $(FILELIST)) hdl/icache_macros.svh
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# the log decides pass or fail, so a crash without the pass line fails too
run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: test/icacheTb.sv
// testbench for icacheTop, seeded random fetches checked against a reference cache model
`timescale 1ns/1ns
`default_nettype none

`include "icache_macros.svh"

module icacheTb;

    localparam int readyTimeout = 200;
    localparam int randomFetches = 400;
    // one window of failing words inside line 3 of tag 0x2a
    localparam logic [`ICACHE_WORD_W-1:0] errLo = {19'h0002A, 7'd3, 4'd5, 2'b00};
    localparam logic [`ICACHE_WORD_W-1:0] errHi = {19'h0002A, 7'd3, 4'd6, 2'b00};

    logic           clk;
    logic           rstN;
    apbPkg::apbReqT cpuReq;
    apbPkg::apbRspT cpuRsp;
    apbPkg::apbReqT memReq;
    apbPkg::apbRspT memRsp;

    int    seed = 32'h1baa79c3;
    string testName = "reset";

    // memory side bookkeeping
    int                        waitLeft;
    logic [`ICACHE_WORD_W-1:0] pendAddr;
    logic [`ICACHE_WORD_W-1:0] memReads [$];

    // reference model, one valid bit and tag per line
    logic                modelValid [`ICACHE_LINES];
    icacheTypesPkg::tagT modelTag   [`ICACHE_LINES];
    icacheTypesPkg::tagT tagSet     [4];

    icacheTop uut (.clk, .rstN, .cpuReq, .cpuRsp, .memReq, .memRsp);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic icacheTypesPkg::instrT memWord(input logic [`ICACHE_WORD_W-1:0] a);
        return a ^ 32'h5ac396e1;
    endfunction

    function automatic logic inErrWindow(input logic [`ICACHE_WORD_W-1:0] a);
        return (a >= errLo) && (a <= errHi);
    endfunction

    function automatic icacheTypesPkg::fetchAddrT makeAddr(input icacheTypesPkg::tagT t,
            input icacheTypesPkg::lineIndexT i, input icacheTypesPkg::wordOffsetT o);
        icacheTypesPkg::fetchAddrT r;
        r.tag        = t;
        r.index      = i;
        r.offset     = o;
        r.byteOffset = '0;
        return r;
    endfunction

    task automatic abortRun();
        $display("RESULT: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic compareInstr(input string name, input icacheTypesPkg::instrT expected,
            input icacheTypesPkg::instrT actual);
        if (expected !== actual) begin
            $display("[FAIL] %s %s expected %08h actual %08h", testName, name, expected, actual);
            abortRun();
        end
    endtask

    task automatic compareFlag(input string name, input logic expected, input logic actual);
        if (expected !== actual) begin
            $display("[FAIL] %s %s expected %b actual %b", testName, name, expected, actual);
            abortRun();
        end
    endtask

    task automatic compareCount(input string name, input int expected, input int actual);
        if (expected != actual) begin
            $display("[FAIL] %s %s expected %0d actual %0d", testName, name, expected, actual);
            abortRun();
        end
    endtask

    task automatic compareAddr(input string name, input logic [`ICACHE_WORD_W-1:0] expected,
            input logic [`ICACHE_WORD_W-1:0] actual);
        if (expected !== actual) begin
            $display("[FAIL] %s %s expected %08h actual %08h", testName, name, expected, actual);
            abortRun();
        end
    endtask

    // APB memory, random wait states picked in the setup cycle
    initial begin : memoryModel
        forever begin
            @(posedge clk);
            #1;
            memRsp = '0;
            if (rstN && memReq.sel && !memReq.enable) begin
                pendAddr = memReq.addr;
                waitLeft = $random(seed) & 3;
            end else if (rstN && memReq.sel && memReq.enable) begin
                // address must hold for the whole transfer
                compareAddr("memAddrStable", pendAddr, memReq.addr);
                compareFlag("memReadKind", 1'b0, memReq.kind);
                if (waitLeft == 0) begin
                    memRsp.ready  = 1'b1;
                    memRsp.slverr = inErrWindow(memReq.addr);
                    memRsp.rdata  = memWord(memReq.addr);
                    memReads.push_back(memReq.addr);
                end else begin
                    waitLeft--;
                end
            end
        end
    end

    // one processor transfer, predicted and checked against the model
    task automatic runFetch(input apbPkg::accessKindT kind, input icacheTypesPkg::fetchAddrT addr);
        icacheTypesPkg::lineIndexT idx;
        logic [`ICACHE_WORD_W-1:0] lineBase;
        apbPkg::apbRspT            rsp;
        logic                      expHit;
        logic                      expErr;
        int                        expReads;
        int                        cycles;
        idx      = addr.index;
        lineBase = {addr.tag, addr.index, 6'b0};
        expHit   = modelValid[idx] && (modelTag[idx] == addr.tag);
        expErr   = 1'b0;
        expReads = 0;
        if (kind == apbPkg::WRITE) begin
            expErr = 1'b1;
        end else if (!expHit) begin
            expReads = `ICACHE_WORDS;
            // lowest failing word ends the refill
            for (int i = `ICACHE_WORDS - 1; i >= 0; i--) begin
                if (inErrWindow(lineBase + 32'(4 * i))) begin
                    expReads = i + 1;
                    expErr   = 1'b1;
                end
            end
        end
        cpuReq.sel    = 1'b1;
        cpuReq.enable = 1'b0;
        cpuReq.kind   = kind;
        cpuReq.addr   = addr;
        @(posedge clk);
        #1;
        cpuReq.enable = 1'b1;
        cycles = 0;
        @(negedge clk);
        while (!cpuRsp.ready) begin
            if (cycles >= readyTimeout) begin
                $display("processor transfer at %08h got no ready in time", addr);
                abortRun();
            end
            cycles++;
            @(negedge clk);
        end
        rsp = cpuRsp;
        // writes and hits answer in the first access cycle
        compareFlag("hitClass", (kind == apbPkg::WRITE) || expHit, cycles == 0);
        compareFlag("slverr", expErr, rsp.slverr);
        if (!expErr) begin
            compareInstr("rdata", memWord(addr), rsp.rdata);
        end
        compareCount("memoryReads", expReads, memReads.size());
        foreach (memReads[i]) begin
            compareAddr("readAddress", lineBase + 32'(4 * i), memReads[i]);
        end
        if (kind == apbPkg::READ && !expHit) begin
            modelValid[idx] = !expErr;
            modelTag[idx]   = addr.tag;
        end
        @(posedge clk);
        #1;
        cpuReq = '0;
        memReads.delete();
    endtask

    initial begin : stimulus
        apbPkg::accessKindT kind;
        cpuReq = '0;
        memRsp = '0;
        rstN   = 1'b0;
        tagSet[0] = 19'h00010;
        tagSet[1] = 19'h00011;
        tagSet[2] = 19'h00012;
        tagSet[3] = 19'h0002A;
        for (int i = 0; i < `ICACHE_LINES; i++) begin
            modelValid[i] = 1'b0;
            modelTag[i]   = '0;
        end
        repeat (2) @(posedge clk);
        #1;
        rstN = 1'b1;
        compareFlag("resetReady", 1'b0, cpuRsp.ready);
        compareFlag("resetSlverr", 1'b0, cpuRsp.slverr);
        compareFlag("resetMemSel", 1'b0, memReq.sel);
        compareFlag("resetMemEnable", 1'b0, memReq.enable);

        testName = "coldMiss";
        runFetch(apbPkg::READ, makeAddr(tagSet[0], 7'd5, 4'd9));
        testName = "repeatHit";
        runFetch(apbPkg::READ, makeAddr(tagSet[0], 7'd5, 4'd2));
        testName = "conflictEvict";
        runFetch(apbPkg::READ, makeAddr(tagSet[1], 7'd5, 4'd0));
        runFetch(apbPkg::READ, makeAddr(tagSet[0], 7'd5, 4'd9));
        testName = "refillError";
        runFetch(apbPkg::READ, makeAddr(tagSet[3], 7'd3, 4'd12));
        runFetch(apbPkg::READ, makeAddr(tagSet[3], 7'd3, 4'd1));
        testName = "writeRefused";
        runFetch(apbPkg::WRITE, makeAddr(tagSet[0], 7'd5, 4'd4));
        runFetch(apbPkg::READ, makeAddr(tagSet[0], 7'd5, 4'd4));

        // small tag and index sets keep hits and conflicts both frequent
        testName = "randomFetch";
        for (int n = 0; n < randomFetches; n++) begin
            kind = (($random(seed) & 7) == 0) ? apbPkg::WRITE : apbPkg::READ;
            runFetch(kind, makeAddr(tagSet[$random(seed) & 3], 7'($random(seed) & 7),
                                    4'($random(seed) & 15)));
        end
        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: hdl/icacheTop.sv
// instruction cache top level, APB completer to the processor and APB requester to memory
`timescale 1ns/1ns
`default_nettype none

module icacheTop (
    input  logic           clk,
    input  logic           rstN,
    input  apbPkg::apbReqT cpuReq,
    output apbPkg::apbRspT cpuRsp,
    output apbPkg::apbReqT memReq,
    input  apbPkg::apbRspT memRsp
);

    // lookup path
    icacheTypesPkg::tagLookupT  lookup;
    icacheTypesPkg::instrT      lookupWord;
    icacheTypesPkg::lineIndexT  lookupIndex;
    icacheTypesPkg::wordOffsetT lookupOffset;

    // refill path
    logic                       tagWriteEn;
    logic                       tagInvalidateEn;
    icacheTypesPkg::lineIndexT  fillIndex;
    icacheTypesPkg::wordOffsetT fillOffset;
    icacheTypesPkg::tagT        fillTag;
    logic                       fillWordEn;
    icacheTypesPkg::instrT      fillWord;

    tagStore tags (
        .clk, .rstN, .lookupIndex, .lookup,
        .writeEn(tagWriteEn), .writeIndex(fillIndex), .writeTag(fillTag),
        .invalidateEn(tagInvalidateEn)
    );

    dataStore words (
        .clk, .readIndex(lookupIndex), .readOffset(lookupOffset), .readWord(lookupWord),
        .writeEn(fillWordEn), .writeIndex(fillIndex), .writeOffset(fillOffset),
        .writeWord(fillWord)
    );

    // controller owns both buses
    missController ctrl (
        .clk, .rstN, .cpuReq, .cpuRsp, .memReq, .memRsp,
        .lookup, .lookupWord, .lookupIndex, .lookupOffset,
        .tagWriteEn, .tagInvalidateEn, .fillIndex, .fillOffset, .fillTag,
        .fillWordEn, .fillWord
    );

endmodule

`default_nettype wire

// File: hdl/missController.sv
// hit/miss decision, processor APB response and line refill FSM over the memory APB port
`timescale 1ns/1ns
`default_nettype none

module missController (
    input  logic                       clk,
    input  logic                       rstN,
    // processor port
    input  apbPkg::apbReqT             cpuReq,
    output apbPkg::apbRspT             cpuRsp,
    // memory port
    output apbPkg::apbReqT             memReq,
    input  apbPkg::apbRspT             memRsp,
    // lookup results from both stores
    input  icacheTypesPkg::tagLookupT  lookup,
    input  icacheTypesPkg::instrT      lookupWord,
    output icacheTypesPkg::lineIndexT  lookupIndex,
    output icacheTypesPkg::wordOffsetT lookupOffset,
    // refill writes
    output logic                       tagWriteEn,
    output logic                       tagInvalidateEn,
    output icacheTypesPkg::lineIndexT  fillIndex,
    output icacheTypesPkg::wordOffsetT fillOffset,
    output icacheTypesPkg::tagT        fillTag,
    output logic                       fillWordEn,
    output icacheTypesPkg::instrT      fillWord
);

    icacheTypesPkg::ctrlStateT state;
    icacheTypesPkg::ctrlStateT stateNext;

    // processor address as seen on the bus, and latched at setup
    icacheTypesPkg::fetchAddrT cpuAddr;
    icacheTypesPkg::fetchAddrT reqAddr;
    // word the processor asked for, caught during refill
    icacheTypesPkg::instrT     savedWord;
    logic                      hit;

    assign cpuAddr = icacheTypesPkg::fetchAddrT'(cpuReq.addr);

    // stores are addressed straight from the bus, valid in the setup cycle
    assign lookupIndex  = cpuAddr.index;
    assign lookupOffset = cpuAddr.offset;

    // the only place tag and data results meet
    assign hit = lookup.valid && (lookup.tag == reqAddr.tag);

    // refill targets the latched line
    assign fillIndex = reqAddr.index;
    assign fillTag   = reqAddr.tag;
    assign fillWord  = memRsp.rdata;

    // memory request, built from registers only so it holds under wait states
    always_comb begin
        memReq.sel    = (state == icacheTypesPkg::REFILL_SETUP)
                     || (state == icacheTypesPkg::REFILL_ACCESS);
        memReq.enable = (state == icacheTypesPkg::REFILL_ACCESS);
        memReq.kind   = apbPkg::READ;
        memReq.addr   = {reqAddr.tag, reqAddr.index, fillOffset, 2'b00};
    end

    // next state and the per-cycle strobes
    always_comb begin
        stateNext       = state;
        cpuRsp          = '0;
        tagInvalidateEn = 1'b0;
        tagWriteEn      = 1'b0;
        fillWordEn      = 1'b0;
        case (state)
            icacheTypesPkg::IDLE: begin
                if (cpuReq.sel && !cpuReq.enable) begin
                    stateNext = icacheTypesPkg::LOOKUP;
                end
            end
            // first access cycle, lookup results are here
            icacheTypesPkg::LOOKUP: begin
                if (cpuReq.kind == apbPkg::WRITE) begin
                    cpuRsp.ready  = 1'b1;
                    cpuRsp.slverr = 1'b1;
                    stateNext     = icacheTypesPkg::IDLE;
                end else if (hit) begin
                    cpuRsp.ready = 1'b1;
                    cpuRsp.rdata = lookupWord;
                    stateNext    = icacheTypesPkg::IDLE;
                end else begin
                    // line is invalid until the last word lands
                    tagInvalidateEn = 1'b1;
                    stateNext       = icacheTypesPkg::REFILL_SETUP;
                end
            end
            icacheTypesPkg::REFILL_SETUP: begin
                stateNext = icacheTypesPkg::REFILL_ACCESS;
            end
            icacheTypesPkg::REFILL_ACCESS: begin
                if (memRsp.ready && memRsp.slverr) begin
                    stateNext = icacheTypesPkg::ERROR_RESP;
                end else if (memRsp.ready) begin
                    fillWordEn = 1'b1;
                    if (fillOffset == '1) begin
                        stateNext = icacheTypesPkg::RESPOND;
                    end else begin
                        stateNext = icacheTypesPkg::REFILL_SETUP;
                    end
                end
            end
            // all 16 words written, now the tag goes valid
            icacheTypesPkg::RESPOND: begin
                tagWriteEn   = 1'b1;
                cpuRsp.ready = 1'b1;
                cpuRsp.rdata = savedWord;
                stateNext    = icacheTypesPkg::IDLE;
            end
            icacheTypesPkg::ERROR_RESP: begin
                cpuRsp.ready  = 1'b1;
                cpuRsp.slverr = 1'b1;
                stateNext     = icacheTypesPkg::IDLE;
            end
            default: begin
                stateNext = icacheTypesPkg::IDLE;
            end
        endcase
    end

    // control state
    always_ff @(posedge clk) begin
        if (!rstN) begin
            state      <= icacheTypesPkg::IDLE;
            fillOffset <= '0;
        end else begin
            state <= stateNext;
            if (tagInvalidateEn) begin
                fillOffset <= '0;
            end else if (fillWordEn) begin
                // wraps back to 0 after the last word
                fillOffset <= fillOffset + 1'b1;
            end
        end
    end

    // request and returned word
    always_ff @(posedge clk) begin
        if (state == icacheTypesPkg::IDLE && cpuReq.sel && !cpuReq.enable) begin
            reqAddr <= cpuAddr;
        end
        if (fillWordEn && fillOffset == reqAddr.offset) begin
            savedWord <= memRsp.rdata;
        end
    end

    // memory sees a steady address for the whole transfer
    memAddrStable: assert property (
        @(posedge clk) disable iff (!rstN)
        (memReq.sel && !memRsp.ready) |=> $stable(memReq.addr)
    ) else $error("memory address changed while the transfer was pending");

    // processor only gets ready in its access phase
    cpuReadyInAccess: assert property (
        @(posedge clk) disable iff (!rstN)
        cpuRsp.ready |-> (cpuReq.sel && cpuReq.enable)
    ) else $error("processor ready outside an access phase");

endmodule

`default_nettype wire

// File: hdl/dataStore.sv
// instruction word array of the cache, registered word read and single-word refill write
`timescale 1ns/1ns
`default_nettype none

`include "icache_macros.svh"

module dataStore (
    input  logic                       clk,
    // read side follows the tag store lookup
    input  icacheTypesPkg::lineIndexT  readIndex,
    input  icacheTypesPkg::wordOffsetT readOffset,
    output icacheTypesPkg::instrT      readWord,
    // one word per refill beat
    input  logic                       writeEn,
    input  icacheTypesPkg::lineIndexT  writeIndex,
    input  icacheTypesPkg::wordOffsetT writeOffset,
    input  icacheTypesPkg::instrT      writeWord
);

    localparam int depth = `ICACHE_LINES * `ICACHE_WORDS;

    // flat word array, line index in the upper address bits
    icacheTypesPkg::instrT wordArray [depth];

    // combined word addresses
    logic [$clog2(depth)-1:0] readAddr;
    logic [$clog2(depth)-1:0] writeAddr;

    assign readAddr  = {readIndex, readOffset};
    assign writeAddr = {writeIndex, writeOffset};

    // refill beat
    always_ff @(posedge clk) begin
        if (writeEn) begin
            wordArray[writeAddr] <= writeWord;
        end
    end

    // registered read
    // a word written at this edge shows up on a read one cycle later
    always_ff @(posedge clk) begin
        readWord <= wordArray[readAddr];
    end

endmodule

`default_nettype wire

// File: hdl/tagStore.sv
// tag and valid arrays of the direct mapped cache, one-cycle registered lookup
`timescale 1ns/1ns
`default_nettype none

`include "icache_macros.svh"

module tagStore (
    input  logic                    clk,
    input  logic                    rstN,
    // read side, index from the processor setup phase
    input  icacheTypesPkg::lineIndexT lookupIndex,
    output icacheTypesPkg::tagLookupT lookup,
    // refill side
    input  logic                    writeEn,
    input  icacheTypesPkg::lineIndexT writeIndex,
    input  icacheTypesPkg::tagT     writeTag,
    input  logic                    invalidateEn
);

    // tags need no reset, the valid bit guards them
    icacheTypesPkg::tagT tagArray [`ICACHE_LINES];

    // one valid bit per line
    logic [`ICACHE_LINES-1:0] validBits;

    // tag written together with the valid bit at the end of a refill
    always_ff @(posedge clk) begin
        if (writeEn) begin
            tagArray[writeIndex] <= writeTag;
        end
    end

    // valid bits
    // cleared at reset, dropped when a refill starts, set when it finishes
    always_ff @(posedge clk) begin
        if (!rstN) begin
            validBits <= '0;
        end else if (writeEn) begin
            validBits[writeIndex] <= 1'b1;
        end else if (invalidateEn) begin
            validBits[writeIndex] <= 1'b0;
        end
    end

    // registered lookup
    // result lines up with the first access cycle of the processor
    always_ff @(posedge clk) begin
        lookup.valid <= validBits[lookupIndex];
        lookup.tag   <= tagArray[lookupIndex];
    end

    // controller only invalidates at refill start and writes at refill end
    writeInvalidateExclusive: assert property (
        @(posedge clk) disable iff (!rstN)
        !(writeEn && invalidateEn)
    ) else $error("tag write and invalidate in the same cycle");

endmodule

`default_nettype wire

// File: hdl/icacheTypesPkg.sv
// cache address fields, lookup results and controller states shared by the cache modules
`default_nettype none

`include "icache_macros.svh"

package icacheTypesPkg;

    // field widths derived from the geometry
    localparam int indexW  = $clog2(`ICACHE_LINES);
    localparam int offsetW = $clog2(`ICACHE_WORDS);
    localparam int byteW   = $clog2(`ICACHE_WORD_W / 8);
    localparam int tagW    = `ICACHE_WORD_W - indexW - offsetW - byteW;

    typedef logic [indexW-1:0]         lineIndexT;
    typedef logic [offsetW-1:0]        wordOffsetT;
    typedef logic [tagW-1:0]           tagT;
    typedef logic [`ICACHE_WORD_W-1:0] instrT;

    // overlays a byte address, msb first
    typedef struct packed {
        tagT        tag;
        lineIndexT  index;
        wordOffsetT offset;
        logic [byteW-1:0] byteOffset;
    } fetchAddrT;

    // one tag store entry as it comes out of the lookup
    typedef struct packed {
        logic valid;
        tagT  tag;
    } tagLookupT;

    // refill walks SETUP/ACCESS once per word
    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        REFILL_SETUP,
        REFILL_ACCESS,
        RESPOND,
        ERROR_RESP
    } ctrlStateT;

endpackage

`default_nettype wire

// File: hdl/apbPkg.sv
// APB request and response bundles used on the processor port and the memory port
`default_nettype none

`include "icache_macros.svh"

package apbPkg;

    // opcode sits where pwrite does
    typedef enum logic {
        READ  = 1'b0,
        WRITE = 1'b1
    } accessKindT;

    // requester side: psel, penable, pwrite, paddr
    typedef struct packed {
        logic                      sel;
        logic                      enable;
        accessKindT                kind;
        logic [`ICACHE_WORD_W-1:0] addr;
    } apbReqT;

    // completer side, rdata and slverr only meaningful with ready
    typedef struct packed {
        logic                      ready;
        logic                      slverr;
        logic [`ICACHE_WORD_W-1:0] rdata;
    } apbRspT;

endpackage

`default_nettype wire

// File: hdl/icache_macros.svh
// cache geometry constants, included by the packages and the store modules
`ifndef ICACHE_MACROS_SVH
`define ICACHE_MACROS_SVH

// number of direct mapped lines
`define ICACHE_LINES 128

// instruction words held by one line
`define ICACHE_WORDS 16

// word width, also the byte address width on both buses
`define ICACHE_WORD_W 32

// 128 lines x 16 words x 4 bytes gives 8 KB of instructions
// changing a value here resizes the address fields in the types package

`endif
